//--- rtl/cpuPkg.sv
package cpuPkg;

    localparam int NUM_REGS = 16;

    typedef logic [3:0]  regIdx;
    typedef logic [31:0] word;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    // The move class keeps its function code in secondLevel[2:0]
    typedef struct packed {
        logic [1:0]         firstLevel;
        logic               special;
        logic [3:0]         secondLevel;
        regIdx              dest;
        regIdx              srcFirst;
        logic               padding;
        logic signed [15:0] imm;
    } instrImm;

    typedef struct packed {
        logic [1:0]  firstLevel;
        logic        special;
        logic [3:0]  secondLevel;
        regIdx       dest;
        regIdx       srcFirst;
        regIdx       srcSec;
        logic [12:0] padding;
    } instrReg;

    typedef union packed {
        instrImm immForm;
        instrReg regForm;
    } instrWord;

    typedef enum logic [2:0] {MOVE, ALUIMM, ALUREG, MEM, BRANCH} opClass;

    typedef struct packed {
        opClass     cls;
        logic [3:0] secondLevel; // Branch condition for BRANCH
        logic [2:0] aluFunc;     // Bit 0 selects store for MEM
        regIdx      dest;
        regIdx      srcFirst;
        regIdx      srcSec;
        word        imm;         // Sign-extended
    } decodedOp;

    typedef struct packed {
        logic writeEnable;
        word  writeData;
        logic memRead;
        logic memWrite;
        word  memAddr;
        word  memData;
        logic branchTaken;
        logic halt;
    } exeResult;

    localparam logic [1:0] CLS_MOVE_ALU = 2'b00;
    localparam logic [1:0] CLS_REG      = 2'b01;
    localparam logic [1:0] CLS_MEM      = 2'b10;
    localparam logic [1:0] CLS_BRANCH   = 2'b11;

    localparam logic [3:0] SL_ADD  = 4'b0001;
    localparam logic [3:0] SL_SUB  = 4'b0010;
    localparam logic [3:0] SL_ADDS = 4'b1001;
    localparam logic [3:0] SL_SUBS = 4'b1010;

    localparam logic [2:0] AF_MOV  = 3'b000;
    localparam logic [2:0] AF_CLR  = 3'b010;
    localparam logic [2:0] AF_HALT = 3'b111;

    localparam logic [3:0] BR_EQ = 4'b0000;
    localparam logic [3:0] BR_NE = 4'b0001;
    localparam logic [3:0] BR_MI = 4'b0100;

    localparam word RESET_PC = 32'd0;

endpackage

//--- rtl/instrDecoder.sv
module instrDecoder (
    input  cpuPkg::instrWord instr,
    output cpuPkg::decodedOp op
);

    always_comb begin
        op.cls = cpuPkg::MOVE;
        case (instr.immForm.firstLevel)
            cpuPkg::CLS_MOVE_ALU: begin
                // Special bit splits plain moves from immediate arithmetic
                op.cls = instr.immForm.special ? cpuPkg::ALUIMM : cpuPkg::MOVE;
            end
            cpuPkg::CLS_REG:    op.cls = cpuPkg::ALUREG;
            cpuPkg::CLS_MEM:    op.cls = cpuPkg::MEM;
            cpuPkg::CLS_BRANCH: op.cls = cpuPkg::BRANCH;
            default:            op.cls = cpuPkg::MOVE;
        endcase
    end

    always_comb begin
        op.secondLevel = instr.immForm.secondLevel;
        op.aluFunc     = instr.immForm.secondLevel[2:0];
        op.dest        = instr.immForm.dest;
        op.srcFirst    = instr.immForm.srcFirst;
        op.srcSec      = instr.regForm.srcSec;           // Register view only
        op.imm         = {{16{instr.immForm.imm[15]}}, instr.immForm.imm};
    end

endmodule

//--- rtl/regFile.sv
module regFile (
    input  logic          clk,
    input  logic          rst,
    input  cpuPkg::regIdx rdDest,
    input  cpuPkg::regIdx rdFirst,
    input  cpuPkg::regIdx rdSec,
    input  logic          wrEn,
    input  cpuPkg::regIdx wrIdx,
    input  cpuPkg::word   wrData,
    output cpuPkg::word   dataDest,
    output cpuPkg::word   dataFirst,
    output cpuPkg::word   dataSec
);

    cpuPkg::word regs [cpuPkg::NUM_REGS];

    // Asynchronous reads
    assign dataDest  = regs[rdDest];
    assign dataFirst = regs[rdFirst];
    assign dataSec   = regs[rdSec];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

//--- rtl/execute.sv
module execute (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::decodedOp op,
    input  cpuPkg::word      dataDest,
    input  cpuPkg::word      dataFirst,
    input  cpuPkg::word      dataSec,
    input  logic             commit,
    output cpuPkg::exeResult res
);

    cpuPkg::flagsT flags;       // NZCV
    cpuPkg::flagsT flagsNext;
    cpuPkg::word   operandB;
    cpuPkg::word   aluOut;
    logic [32:0]   aluWide;     // Bit 32 is carry or borrow
    logic          isSub;
    logic          setsFlags;

    assign operandB = (op.cls == cpuPkg::ALUREG) ? dataSec : op.imm;
    assign isSub    = (op.secondLevel == cpuPkg::SL_SUB) || (op.secondLevel == cpuPkg::SL_SUBS);
    assign aluWide  = isSub ? ({1'b0, dataFirst} - {1'b0, operandB})
                            : ({1'b0, dataFirst} + {1'b0, operandB});
    assign aluOut   = aluWide[31:0];

    always_comb begin
        flagsNext.n = aluOut[31];
        flagsNext.z = (aluOut == '0);
        flagsNext.c = isSub ? ~aluWide[32] : aluWide[32]; // Not borrow on subtract
        if (isSub) begin
            // Operands of opposite sign and result sign flipped
            flagsNext.v = (dataFirst[31] ^ operandB[31]) & (dataFirst[31] ^ aluOut[31]);
        end else begin
            flagsNext.v = ~(dataFirst[31] ^ operandB[31]) & (dataFirst[31] ^ aluOut[31]);
        end
    end

    always_comb begin
        res       = '0;
        setsFlags = 1'b0;
        case (op.cls)
            cpuPkg::MOVE: begin
                case (op.aluFunc)
                    cpuPkg::AF_MOV: begin
                        res.writeEnable = 1'b1;
                        res.writeData   = op.imm;
                    end
                    cpuPkg::AF_CLR:  res.writeEnable = 1'b1; // Data stays zero
                    cpuPkg::AF_HALT: res.halt = 1'b1;
                    default: ;
                endcase
            end
            cpuPkg::ALUIMM, cpuPkg::ALUREG: begin
                case (op.secondLevel)
                    cpuPkg::SL_ADD, cpuPkg::SL_SUB: begin
                        res.writeEnable = 1'b1;
                        res.writeData   = aluOut;
                    end
                    cpuPkg::SL_ADDS, cpuPkg::SL_SUBS: begin
                        res.writeEnable = 1'b1;
                        res.writeData   = aluOut;
                        setsFlags       = 1'b1;
                    end
                    default: ;
                endcase
            end
            cpuPkg::MEM: begin
                res.memAddr = dataFirst + op.imm;
                if (op.aluFunc[0]) begin          // Store
                    res.memWrite = 1'b1;
                    res.memData  = dataDest;
                end else begin
                    res.memRead     = 1'b1;
                    res.writeEnable = 1'b1;       // Sequencer supplies the bus data
                end
            end
            cpuPkg::BRANCH: begin
                case (op.secondLevel)
                    cpuPkg::BR_EQ: res.branchTaken = flags.z;
                    cpuPkg::BR_NE: res.branchTaken = ~flags.z;
                    cpuPkg::BR_MI: res.branchTaken = flags.n;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else if (commit && setsFlags) begin
            flags <= flagsNext;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        res.branchTaken |-> op.cls == cpuPkg::BRANCH)
        else $error("branch taken outside branch class");

endmodule

//--- rtl/sequencer.sv
module sequencer (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::exeResult res,
    input  cpuPkg::decodedOp op,
    input  cpuPkg::word      datRd,
    input  logic             ack,
    output cpuPkg::instrWord instr,
    output logic             commit,
    output logic             wrEn,
    output cpuPkg::word      wrData,
    output logic             cyc,
    output logic             stb,
    output logic             we,
    output cpuPkg::word      adr,
    output cpuPkg::word      datWr,
    output logic             halted
);

    typedef enum logic [2:0] {FETCH, EXEC, ACCESS, COMMIT, HALTED} phaseT;

    phaseT       phase;
    cpuPkg::word pc;
    cpuPkg::word pcNext;
    cpuPkg::word loadData;
    logic        memOp;

    assign memOp  = res.memRead | res.memWrite;
    assign commit = (phase == COMMIT);
    assign halted = (phase == HALTED);
    assign pcNext = res.branchTaken ? pc + op.imm : pc + 32'd1;
    assign wrEn   = commit & res.writeEnable;
    assign wrData = res.memRead ? loadData : res.writeData; // Loads take bus data

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= FETCH;
            pc    <= cpuPkg::RESET_PC;
            cyc   <= 1'b0;
            stb   <= 1'b0;
            we    <= 1'b0;
        end else begin
            case (phase)
                FETCH: begin
                    if (!cyc) begin              // First fetch out of reset
                        cyc <= 1'b1;
                        stb <= 1'b1;
                        we  <= 1'b0;
                    end else if (ack) begin
                        cyc   <= 1'b0;
                        stb   <= 1'b0;
                        phase <= EXEC;
                    end
                end
                EXEC: begin
                    if (memOp) begin
                        cyc   <= 1'b1;
                        stb   <= 1'b1;
                        we    <= res.memWrite;
                        phase <= ACCESS;
                    end else begin
                        phase <= COMMIT;
                    end
                end
                ACCESS: begin
                    if (ack) begin
                        cyc   <= 1'b0;
                        stb   <= 1'b0;
                        we    <= 1'b0;
                        phase <= COMMIT;
                    end
                end
                COMMIT: begin
                    pc <= pcNext;
                    if (res.halt) begin
                        phase <= HALTED;
                    end else begin
                        cyc   <= 1'b1;           // Next fetch starts right away
                        stb   <= 1'b1;
                        phase <= FETCH;
                    end
                end
                HALTED: phase <= HALTED;
                default: phase <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == FETCH && cyc && ack) begin
            instr <= datRd;
        end
        if (phase == ACCESS && ack) begin
            loadData <= datRd;
        end
        if (phase == EXEC && memOp) begin
            adr   <= res.memAddr;
            datWr <= res.memData;
        end else if (phase == COMMIT) begin
            adr <= pcNext;
        end else if (phase == FETCH && !cyc) begin
            adr <= pc;
        end
    end

    assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
        else $error("stb without cyc");

    // Master holds the request until the slave answers
    assert property (@(posedge clk) disable iff (rst)
        stb && !ack |=> $stable({adr, we, datWr}))
        else $error("bus request changed before ack");

endmodule

//--- rtl/cpuTop.sv
module cpuTop (
    input  logic        clk,
    input  logic        rst,
    input  cpuPkg::word datRd,
    input  logic        ack,
    output logic        cyc,
    output logic        stb,
    output logic        we,
    output cpuPkg::word adr,
    output cpuPkg::word datWr,
    output logic        halted
);

    cpuPkg::instrWord instr;
    cpuPkg::decodedOp op;
    cpuPkg::exeResult res;
    cpuPkg::word      dataDest;
    cpuPkg::word      dataFirst;
    cpuPkg::word      dataSec;
    cpuPkg::word      wrData;
    logic             commit;
    logic             wrEn;

    instrDecoder decoder0 (
        .instr (instr),
        .op    (op)
    );

    regFile regs0 (
        .clk       (clk),
        .rst       (rst),
        .rdDest    (op.dest),
        .rdFirst   (op.srcFirst),
        .rdSec     (op.srcSec),
        .wrEn      (wrEn),
        .wrIdx     (op.dest),      // Every write-back targets dest
        .wrData    (wrData),
        .dataDest  (dataDest),
        .dataFirst (dataFirst),
        .dataSec   (dataSec)
    );

    execute exe0 (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .dataDest  (dataDest),
        .dataFirst (dataFirst),
        .dataSec   (dataSec),
        .commit    (commit),
        .res       (res)
    );

    sequencer seq0 (
        .clk    (clk),
        .rst    (rst),
        .res    (res),
        .op     (op),
        .datRd  (datRd),
        .ack    (ack),
        .instr  (instr),
        .commit (commit),
        .wrEn   (wrEn),
        .wrData (wrData),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datWr  (datWr),
        .halted (halted)
    );

endmodule

//--- bench/wbMemory.sv
module wbMemory (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  cpuPkg::word adr,
    input  cpuPkg::word datWr,
    input  cpuPkg::word image [256],
    output cpuPkg::word datRd,
    output logic        ack,
    output cpuPkg::word storeCount,
    output cpuPkg::word lastAdr,
    output cpuPkg::word lastDat
);

    cpuPkg::word mem [256];
    cpuPkg::word lcgState;
    cpuPkg::word lcgDraw;
    logic [1:0]  waitCnt;       // Extra cycles before ack
    logic        busy;

    function automatic cpuPkg::word lcgNext(input cpuPkg::word state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    assign lcgDraw = lcgNext(lcgState);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack        <= 1'b0;
            datRd      <= '0;
            busy       <= 1'b0;
            waitCnt    <= '0;
            lcgState   <= 32'd27739;
            storeCount <= '0;
            lastAdr    <= '0;
            lastDat    <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= image[i];       // Reload the image while reset is held
            end
        end else if (ack) begin
            ack <= 1'b0;                  // Master drops cyc on this edge
        end else if (cyc && stb) begin
            if (!busy) begin
                busy     <= 1'b1;
                lcgState <= lcgDraw;
                waitCnt  <= lcgDraw[17:16];
            end else if (waitCnt != 2'd0) begin
                waitCnt <= waitCnt - 2'd1;
            end else begin
                busy <= 1'b0;
                ack  <= 1'b1;
                if (we) begin
                    mem[adr[7:0]] <= datWr;
                    storeCount    <= storeCount + 32'd1;
                    lastAdr       <= adr;
                    lastDat       <= datWr;
                end else begin
                    datRd <= mem[adr[7:0]];
                end
            end
        end
    end

endmodule

//--- bench/cpuTb.sv
module cpuTb;

    typedef struct packed {
        logic          isFlags;    // Data is a branch marker, not a word
        cpuPkg::word   adr;
        cpuPkg::word   data;
        cpuPkg::flagsT flags;
    } storeEntry;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic        ack;
    logic        halted;
    cpuPkg::word adr;
    cpuPkg::word datWr;
    cpuPkg::word datRd;
    cpuPkg::word storeCount;
    cpuPkg::word lastAdr;
    cpuPkg::word lastDat;
    cpuPkg::word image [256];
    storeEntry   expected [14];
    int          errors;

    cpuTop dut0 (
        .clk    (clk),
        .rst    (rst),
        .datRd  (datRd),
        .ack    (ack),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datWr  (datWr),
        .halted (halted)
    );

    wbMemory slave0 (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .datWr      (datWr),
        .image      (image),
        .datRd      (datRd),
        .ack        (ack),
        .storeCount (storeCount),
        .lastAdr    (lastAdr),
        .lastDat    (lastDat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic cpuPkg::instrWord immInstr(input int cls, input int special, input int sub,
                                                 input int dest, input int src, input int imm);
        cpuPkg::instrWord w;
        w = '0;
        w.immForm.firstLevel  = 2'(cls);
        w.immForm.special     = 1'(special);
        w.immForm.secondLevel = 4'(sub);
        w.immForm.dest        = 4'(dest);
        w.immForm.srcFirst    = 4'(src);
        w.immForm.imm         = 16'(imm);
        return w;
    endfunction

    function automatic cpuPkg::instrWord regInstr(input int sub, input int dest, input int src,
                                                 input int srcSec);
        cpuPkg::instrWord w;
        w = '0;
        w.regForm.firstLevel  = 2'b01;
        w.regForm.secondLevel = 4'(sub);
        w.regForm.dest        = 4'(dest);
        w.regForm.srcFirst    = 4'(src);
        w.regForm.srcSec      = 4'(srcSec);
        return w;
    endfunction

    // Marker starts at 0xC and each branch keeps its bit only when taken
    task automatic addFlagCapture(input int at, input int slot);
        image[at]     = immInstr(0, 0, 0, 10, 0, 'hC);     // MOV r10, #0xC
        image[at + 1] = immInstr(3, 0, 4, 0, 0, 2);        // BMI +2
        image[at + 2] = immInstr(0, 1, 2, 10, 10, 8);      // SUB r10, r10, #8
        image[at + 3] = immInstr(3, 0, 0, 0, 0, 2);        // BEQ +2
        image[at + 4] = immInstr(0, 1, 2, 10, 10, 4);      // SUB r10, r10, #4
        image[at + 5] = immInstr(2, 0, 1, 10, 0, slot);    // ST r10
    endtask

    task automatic buildImage();
        for (int a = 0; a < 256; a++) begin
            image[a] = {16'hC0DE, 8'(a), ~8'(a)};
        end
        image[0]  = immInstr(0, 0, 0, 1, 0, -5);           // MOV r1, #-5
        image[1]  = immInstr(2, 0, 1, 1, 0, 'h80);         // ST r1, [r0+0x80]
        image[2]  = immInstr(0, 0, 2, 1, 0, 0);            // CLR r1
        image[3]  = immInstr(2, 0, 1, 1, 0, 'h81);
        image[4]  = immInstr(0, 0, 0, 2, 0, 'h7FFF);       // MOV r2, #0x7FFF
        image[5]  = immInstr(0, 1, 1, 3, 2, 'h7FFF);       // ADD r3, r2, #0x7FFF
        image[6]  = immInstr(2, 0, 1, 3, 0, 'h82);
        image[7]  = immInstr(0, 0, 0, 4, 0, -1);           // MOV r4, #-1
        image[8]  = regInstr(1, 5, 4, 2);                  // ADD r5, r4, r2 wraps
        image[9]  = immInstr(2, 0, 1, 5, 0, 'h83);
        image[10] = immInstr(0, 1, 2, 6, 0, 1);            // SUB r6, r0, #1
        image[11] = immInstr(2, 0, 1, 6, 0, 'h84);
        image[12] = regInstr(2, 7, 3, 2);                  // SUB r7, r3, r2
        image[13] = immInstr(2, 0, 1, 7, 0, 'h85);
        image[14] = immInstr(0, 0, 0, 9, 0, 'h5A);         // Marker in r9
        image[15] = regInstr('b1010, 8, 2, 7);             // SUBS r8, r2, r7 gives zero
        image[16] = immInstr(3, 0, 0, 0, 0, 2);            // BEQ +2
        image[17] = immInstr(2, 0, 1, 4, 0, 'h86);         // Skipped store
        image[18] = immInstr(2, 0, 1, 9, 0, 'h86);
        image[19] = immInstr(3, 0, 1, 0, 0, 2);            // BNE +2 not taken
        image[20] = immInstr(2, 0, 1, 2, 0, 'h87);
        addFlagCapture(21, 'h88);
        image[27] = regInstr('b1010, 11, 0, 2);            // SUBS r11, r0, r2 negative
        addFlagCapture(28, 'h89);
        image[34] = immInstr(2, 0, 1, 11, 0, 'h8A);
        image[35] = immInstr(0, 1, 'b1001, 12, 4, 1);      // ADDS r12, r4, #1
        image[36] = immInstr(3, 0, 1, 0, 0, 2);            // BNE +2
        image[37] = immInstr(2, 0, 1, 12, 0, 'h8B);
        image[38] = immInstr(2, 0, 0, 13, 0, 'h83);        // LD r13, [r0+0x83]
        image[39] = immInstr(0, 1, 1, 14, 13, 'h1234);
        image[40] = immInstr(2, 0, 1, 14, 0, 'h8C);
        image[41] = immInstr(2, 0, 1, 13, 2, -32626);      // Negative offset lands on 0x8D
        image[42] = immInstr(0, 0, 7, 0, 0, 0);            // HALT
    endtask

    task automatic buildExpected();
        expected[0]  = '{1'b0, 32'h80, 32'hFFFF_FFFB, 4'b0000};
        expected[1]  = '{1'b0, 32'h81, 32'h0000_0000, 4'b0000};
        expected[2]  = '{1'b0, 32'h82, 32'h0000_FFFE, 4'b0000};
        expected[3]  = '{1'b0, 32'h83, 32'h0000_7FFE, 4'b0000};
        expected[4]  = '{1'b0, 32'h84, 32'hFFFF_FFFF, 4'b0000};
        expected[5]  = '{1'b0, 32'h85, 32'h0000_7FFF, 4'b0000};
        expected[6]  = '{1'b0, 32'h86, 32'h0000_005A, 4'b0000};
        expected[7]  = '{1'b0, 32'h87, 32'h0000_7FFF, 4'b0000};
        expected[8]  = '{1'b1, 32'h88, 32'h0, 4'b0100};   // C and V not visible to branches
        expected[9]  = '{1'b1, 32'h89, 32'h0, 4'b1000};
        expected[10] = '{1'b0, 32'h8A, 32'hFFFF_8001, 4'b0000};
        expected[11] = '{1'b0, 32'h8B, 32'h0000_0000, 4'b0000};
        expected[12] = '{1'b0, 32'h8C, 32'h0000_9232, 4'b0000};
        expected[13] = '{1'b0, 32'h8D, 32'h0000_7FFE, 4'b0000};
    endtask

    task automatic compareWord(input string name, input cpuPkg::word got,
                               input cpuPkg::word want);
        if (got !== want) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic matchFlags(input string name, input cpuPkg::flagsT got,
                              input cpuPkg::flagsT want);
        if (got !== want) begin
            $display("[ERROR] %0t %s got nzcv %b expected nzcv %b", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic waitForStore(input cpuPkg::word target, output bit arrived);
        arrived = 1'b0;
        for (int n = 0; n < 500 && !arrived; n++) begin
            @(negedge clk);
            arrived = (storeCount >= target);
        end
    endtask

    task automatic waitForHalt(output bit arrived);
        arrived = 1'b0;
        for (int n = 0; n < 200 && !arrived; n++) begin
            @(negedge clk);
            arrived = halted;
        end
    endtask

    initial begin
        bit arrived;
        bit aborted;
        bit busAfterHalt;
        aborted      = 1'b0;
        busAfterHalt = 1'b0;
        errors       = 0;
        buildImage();
        buildExpected();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < $size(expected) && !aborted; i++) begin
            waitForStore(cpuPkg::word'(i + 1), arrived);
            if (!arrived) begin
                $display("Timed out waiting for store %0d", i);
                errors++;
                aborted = 1'b1;
            end else begin
                compareWord($sformatf("store[%0d].adr", i), lastAdr, expected[i].adr);
                if (expected[i].isFlags) begin
                    matchFlags($sformatf("store[%0d].flags", i),
                               cpuPkg::flagsT'(lastDat[3:0]), expected[i].flags);
                end else begin
                    compareWord($sformatf("store[%0d].data", i), lastDat, expected[i].data);
                end
            end
        end
        if (!aborted) begin
            waitForHalt(arrived);
            if (!arrived) begin
                $display("Core never raised halted");
                errors++;
            end else begin
                repeat (20) begin
                    @(negedge clk);
                    busAfterHalt = busAfterHalt | cyc;
                end
                if (busAfterHalt) begin
                    $display("Bus cycle started after halt");
                    errors++;
                end
            end
            if (storeCount != 32'd14) begin
                $display("Saw %0d stores where 14 were expected", storeCount);
                errors++;
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/cpuPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/execute.sv
rtl/sequencer.sv
rtl/cpuTop.sv
bench/wbMemory.sv
bench/cpuTb.sv

//--- sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module cpuTb -o cpuTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuTb > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
